// ==== flitPkg.sv ====
package flitPkg;

  ////////////////////////////////////////////////////////////////////////////
  // flit word format
  ////////////////////////////////////////////////////////////////////////////

  localparam int flitWidth = 32;

  // flit type codes, carried in the top three bits
  localparam logic [2:0] flitIdHead = 3'b001;
  localparam logic [2:0] flitIdBody = 3'b010;
  localparam logic [2:0] flitIdTail = 3'b011;

  // head flit carries routing and the packet length
  typedef struct packed {
    logic [2:0]  flitId;
    logic [3:0]  dest;
    logic [11:0] length;
    logic [12:0] spare;
  } headFlit;

  // body and tail flits carry payload only
  typedef struct packed {
    logic [2:0]           flitId;
    logic [flitWidth-4:0] payload;
  } bodyFlit;

  // same 32-bit word, decoded by its flitId
  typedef union packed {
    headFlit head;
    bodyFlit body;
  } flitWord;

endpackage

// ==== arbPkg.sv ====
package arbPkg;

  ////////////////////////////////////////////////////////////////////////////
  // port numbering
  ////////////////////////////////////////////////////////////////////////////

  localparam int numPorts = 5;

  localparam int portLocal = 0;
  localparam int portNorth = 1;
  localparam int portEast  = 2;
  localparam int portWest  = 3;
  localparam int portSouth = 4;

  ////////////////////////////////////////////////////////////////////////////
  // arbiter state, one-hot
  ////////////////////////////////////////////////////////////////////////////

  localparam int stateWidth = 6;

  // bit 0 is idle, bit n+1 grants port n
  localparam logic [stateWidth-1:0] stateIdle  = 6'b000001;
  localparam logic [stateWidth-1:0] stateLocal = 6'b000010;
  localparam logic [stateWidth-1:0] stateNorth = 6'b000100;
  localparam logic [stateWidth-1:0] stateEast  = 6'b001000;
  localparam logic [stateWidth-1:0] stateWest  = 6'b010000;
  localparam logic [stateWidth-1:0] stateSouth = 6'b100000;

  // hold limit, same width as the head flit length field
  localparam int lengthWidth = 12;

endpackage

// ==== holdTimer.sv ====
`timescale 1ns/1ns

module holdTimer
  import flitPkg::*, arbPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  flitWord flit,
  input  logic    runTimer,
  output logic    timesUp
);

  logic [lengthWidth-1:0] holdLimit;
  logic [lengthWidth-1:0] holdCount;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdLimit <= '0;
      holdCount <= '0;
    end
    else
    begin
      // any head flit on this input reloads the limit
      if (flit.head.flitId == flitIdHead)
        holdLimit <= flit.head.length;
      if (runTimer)
        holdCount <= holdCount + 1'b1;
      else
        holdCount <= '0;
    end
  end

  assign timesUp = (holdCount == holdLimit);

endmodule

// ==== portArbiter.sv ====
`timescale 1ns/1ns

module portArbiter
  import flitPkg::*, arbPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  flitWord               lFlit,
  input  flitWord               nFlit,
  input  flitWord               eFlit,
  input  flitWord               wFlit,
  input  flitWord               sFlit,
  input  logic                  lReq,
  input  logic                  nReq,
  input  logic                  eReq,
  input  logic                  wReq,
  input  logic                  sReq,
  output logic [stateWidth-1:0] grantState
);

  logic [stateWidth-1:0] nextState;
  logic [numPorts-1:0]   req;
  logic [numPorts-1:0]   runTimer;
  logic [numPorts-1:0]   timesUp;
  logic                  curValid;
  int                    curPort;

  assign req[portLocal] = lReq;
  assign req[portNorth] = nReq;
  assign req[portEast]  = eReq;
  assign req[portWest]  = wReq;
  assign req[portSouth] = sReq;

  ////////////////////////////////////////////////////////////////////////////
  // hold timers
  ////////////////////////////////////////////////////////////////////////////

  holdTimer lTimer (
    .clk      (clk),
    .rst      (rst),
    .flit     (lFlit),
    .runTimer (runTimer[portLocal]),
    .timesUp  (timesUp[portLocal])
  );

  holdTimer nTimer (
    .clk      (clk),
    .rst      (rst),
    .flit     (nFlit),
    .runTimer (runTimer[portNorth]),
    .timesUp  (timesUp[portNorth])
  );

  holdTimer eTimer (
    .clk      (clk),
    .rst      (rst),
    .flit     (eFlit),
    .runTimer (runTimer[portEast]),
    .timesUp  (timesUp[portEast])
  );

  holdTimer wTimer (
    .clk      (clk),
    .rst      (rst),
    .flit     (wFlit),
    .runTimer (runTimer[portWest]),
    .timesUp  (timesUp[portWest])
  );

  holdTimer sTimer (
    .clk      (clk),
    .rst      (rst),
    .flit     (sFlit),
    .runTimer (runTimer[portSouth]),
    .timesUp  (timesUp[portSouth])
  );

  ////////////////////////////////////////////////////////////////////////////
  // grant state machine
  ////////////////////////////////////////////////////////////////////////////

  // first pending port scanning from start, wrapping around
  function automatic logic [stateWidth-1:0] firstFrom(
    input logic [numPorts-1:0] pending,
    input int                  start
  );
    logic [stateWidth-1:0] pick;
    int                    idx;
    pick = stateIdle;
    for (int k = numPorts - 1; k >= 0; k--)
    begin
      idx = (start + k) % numPorts;
      if (pending[idx])
        pick = stateWidth'(2) << idx;
    end
    return pick;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
      grantState <= stateIdle;
    else
      grantState <= nextState;
  end

  always_comb
  begin
    runTimer = '0;
    curValid = 1'b1;
    curPort  = portLocal;
    case (grantState)
      stateLocal: curPort = portLocal;
      stateNorth: curPort = portNorth;
      stateEast:  curPort = portEast;
      stateWest:  curPort = portWest;
      stateSouth: curPort = portSouth;
      default:    curValid = 1'b0;
    endcase

    if (!curValid)
      nextState = firstFrom(req, portLocal);
    else if (req[curPort] && !timesUp[curPort])
    begin
      // keep the grant and let its timer run
      runTimer[curPort] = 1'b1;
      nextState         = grantState;
    end
    else
      // pass on in rotation, the current port is not retried
      nextState = firstFrom(req & ~(numPorts'(1) << curPort), (curPort + 1) % numPorts);
  end

endmodule

// ==== flitStage.sv ====
`timescale 1ns/1ns

module flitStage
  import flitPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  flitWord lFlit,
  input  flitWord nFlit,
  input  flitWord eFlit,
  input  flitWord wFlit,
  input  flitWord sFlit,
  output flitWord lFlitQ,
  output flitWord nFlitQ,
  output flitWord eFlitQ,
  output flitWord wFlitQ,
  output flitWord sFlitQ
);

  // same edge as the grant register, so data lines up with grantState
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lFlitQ <= '0;
      nFlitQ <= '0;
      eFlitQ <= '0;
      wFlitQ <= '0;
      sFlitQ <= '0;
    end
    else
    begin
      lFlitQ <= lFlit;
      nFlitQ <= nFlit;
      eFlitQ <= eFlit;
      wFlitQ <= wFlit;
      sFlitQ <= sFlit;
    end
  end

endmodule

// ==== outputMux.sv ====
`timescale 1ns/1ns

module outputMux
  import flitPkg::*, arbPkg::*;
(
  input  logic [stateWidth-1:0] grantState,
  input  flitWord               lFlitQ,
  input  flitWord               nFlitQ,
  input  flitWord               eFlitQ,
  input  flitWord               wFlitQ,
  input  flitWord               sFlitQ,
  output flitWord               outFlit,
  output logic                  outValid,
  output logic                  outHead,
  output logic [numPorts-1:0]   outGrant
);

  // granted port's word, zero while idle
  always_comb
  begin
    case (grantState)
      stateLocal: outFlit = lFlitQ;
      stateNorth: outFlit = nFlitQ;
      stateEast:  outFlit = eFlitQ;
      stateWest:  outFlit = wFlitQ;
      stateSouth: outFlit = sFlitQ;
      default:    outFlit = '0;
    endcase
  end

  assign outValid = (grantState != stateIdle);

  // idle word has flitId zero, so no head strobe then
  assign outHead = (outFlit.body.flitId == flitIdHead);

  // drop the idle bit, leaving one bit per port
  assign outGrant = grantState[stateWidth-1:1];

endmodule

// ==== routerOutputPort.sv ====
`timescale 1ns/1ns

module routerOutputPort
  import flitPkg::*, arbPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  flitWord             lFlit,
  input  flitWord             nFlit,
  input  flitWord             eFlit,
  input  flitWord             wFlit,
  input  flitWord             sFlit,
  input  logic                lReq,
  input  logic                nReq,
  input  logic                eReq,
  input  logic                wReq,
  input  logic                sReq,
  output flitWord             outFlit,
  output logic                outValid,
  output logic                outHead,
  output logic [numPorts-1:0] outGrant
);

  logic [stateWidth-1:0] grantState;
  flitWord               lFlitQ;
  flitWord               nFlitQ;
  flitWord               eFlitQ;
  flitWord               wFlitQ;
  flitWord               sFlitQ;

  portArbiter portArbiter_inst (
    .clk        (clk),
    .rst        (rst),
    .lFlit      (lFlit),
    .nFlit      (nFlit),
    .eFlit      (eFlit),
    .wFlit      (wFlit),
    .sFlit      (sFlit),
    .lReq       (lReq),
    .nReq       (nReq),
    .eReq       (eReq),
    .wReq       (wReq),
    .sReq       (sReq),
    .grantState (grantState)
  );

  // flit registers run alongside the arbiter
  flitStage flitStage_inst (
    .clk    (clk),
    .rst    (rst),
    .lFlit  (lFlit),
    .nFlit  (nFlit),
    .eFlit  (eFlit),
    .wFlit  (wFlit),
    .sFlit  (sFlit),
    .lFlitQ (lFlitQ),
    .nFlitQ (nFlitQ),
    .eFlitQ (eFlitQ),
    .wFlitQ (wFlitQ),
    .sFlitQ (sFlitQ)
  );

  outputMux outputMux_inst (
    .grantState (grantState),
    .lFlitQ     (lFlitQ),
    .nFlitQ     (nFlitQ),
    .eFlitQ     (eFlitQ),
    .wFlitQ     (wFlitQ),
    .sFlitQ     (sFlitQ),
    .outFlit    (outFlit),
    .outValid   (outValid),
    .outHead    (outHead),
    .outGrant   (outGrant)
  );

endmodule

// ==== routerOutputPort_assertions.sv ====
`timescale 1ns/1ns

module routerOutputPort_assertions
  import arbPkg::*;
(
  input logic                clk,
  input logic                rst,
  input logic                outValid,
  input logic                outHead,
  input logic [numPorts-1:0] outGrant
);

  int assertErrors = 0;

  ////////////////////////////////////////////////////////////////////////////
  // grant and output checks
  ////////////////////////////////////////////////////////////////////////////

  // at most one port owns the output
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(outGrant))
  else
  begin
    assertErrors++;
    $error("outGrant %b grants more than one port", outGrant);
  end

  validMatchesGrant: assert property (@(posedge clk) disable iff (rst)
                                      outValid == (|outGrant))
  else
  begin
    assertErrors++;
    $error("outValid %b does not match outGrant %b", outValid, outGrant);
  end

  // head strobe only on a forwarded word
  headNeedsValid: assert property (@(posedge clk) disable iff (rst) outHead |-> outValid)
  else
  begin
    assertErrors++;
    $error("outHead is high while outValid is low");
  end

endmodule

bind routerOutputPort routerOutputPort_assertions assertCheck (
  .clk      (clk),
  .rst      (rst),
  .outValid (outValid),
  .outHead  (outHead),
  .outGrant (outGrant)
);

// ==== tb_routerOutputPort.sv ====
`timescale 1ns/1ns

module tbClockGen
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

endmodule

module tb_routerOutputPort
  import flitPkg::*, arbPkg::*;
();

  localparam logic [1:0] kindZero = 2'd0;
  localparam logic [1:0] kindHead = 2'd1;
  localparam logic [1:0] kindBody = 2'd2;

  logic                   clk;
  logic                   rst;
  logic [numPorts-1:0]    drvReq;
  flitWord                drvFlit [numPorts];
  flitWord                outFlit;
  logic                   outValid;
  logic                   outHead;
  logic [numPorts-1:0]    outGrant;

  // stimulus table, kinds hold two bits per port with Local lowest
  string                  rowName [$];
  logic [numPorts-1:0]    rowReq [$];
  logic [9:0]             rowKinds [$];
  int                     rowLen [$];
  int                     rowCycles [$];
  string                  rowSeq [$];
  int                     totalCycles;
  logic                   tableReady;

  // reference model, modelPort is -1 while idle
  int                     modelPort;
  logic [lengthWidth-1:0] modelLimit [numPorts];
  logic [lengthWidth-1:0] modelCount [numPorts];
  flitWord                expFlit;

  logic [31:0]            lcgState;
  int                     errorCount;
  int                     checkCount;

  tbClockGen clockGen (.clk(clk));

  routerOutputPort routerOutputPort_inst (
    .clk      (clk),
    .rst      (rst),
    .lFlit    (drvFlit[portLocal]),
    .nFlit    (drvFlit[portNorth]),
    .eFlit    (drvFlit[portEast]),
    .wFlit    (drvFlit[portWest]),
    .sFlit    (drvFlit[portSouth]),
    .lReq     (drvReq[portLocal]),
    .nReq     (drvReq[portNorth]),
    .eReq     (drvReq[portEast]),
    .wReq     (drvReq[portWest]),
    .sReq     (drvReq[portSouth]),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outHead  (outHead),
    .outGrant (outGrant)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcgStep(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [numPorts-1:0] grantOfLetter(input byte c);
    case (c)
      "L":     return 5'b00001;
      "N":     return 5'b00010;
      "E":     return 5'b00100;
      "W":     return 5'b01000;
      "S":     return 5'b10000;
      default: return 5'b00000;
    endcase
  endfunction

  function automatic flitWord makeFlit(input logic [1:0] kind, input int port,
                                       input int len, input logic [31:0] rnd);
    flitWord w;
    w = '0;
    if (kind == kindHead)
    begin
      w.head.flitId = flitIdHead;
      w.head.dest   = 4'(port);
      w.head.length = lengthWidth'(len);
    end
    else if (kind == kindBody)
    begin
      w.body.flitId  = flitIdBody;
      w.body.payload = rnd[31:3];
    end
    return w;
  endfunction

  task automatic addRow(input string name, input logic [numPorts-1:0] req,
                        input logic [9:0] kinds, input int len, input int cycles,
                        input string seq);
    rowName.push_back(name);
    rowReq.push_back(req);
    rowKinds.push_back(kinds);
    rowLen.push_back(len);
    rowCycles.push_back(cycles);
    rowSeq.push_back(seq);
    totalCycles += cycles;
  endtask

  // req is S W E N L, kinds likewise; seq lists the expected grant letters
  task automatic buildTable();
    addRow("resetIdle", 5'b00000, {5{kindZero}}, 0, 4, "----");
    addRow("rotateAll", 5'b11111, {5{kindBody}}, 0, 7, "LNEWSLN");
    addRow("dropAll", 5'b00000, {5{kindBody}}, 0, 2, "--");
    addRow("northHead", 5'b00010, {kindZero, kindZero, kindZero, kindHead, kindZero}, 4, 1, "N");
    addRow("northHold", 5'b00010, {kindZero, kindZero, kindZero, kindBody, kindZero}, 0, 8,
           "NNNN-NNN");
    addRow("northToEast", 5'b00110, {kindZero, kindZero, kindBody, kindBody, kindZero}, 0, 4,
           "NNEN");
    addRow("westOnly", 5'b01000, {kindZero, kindBody, kindZero, kindZero, kindZero}, 0, 1, "W");
    addRow("westToSouth", 5'b10001, {kindBody, kindZero, kindZero, kindZero, kindBody}, 0, 3,
           "SLS");
    addRow("headPayload", 5'b11111, {kindHead, kindBody, kindHead, kindBody, kindHead}, 2, 12,
           "");
    addRow("dropIdle", 5'b00000, {5{kindZero}}, 0, 2, "--");
  endtask

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (expected !== actual)
    begin
      errorCount++;
      $display("Error in %s: expected %h, actual %h", what, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model and per-cycle flow
  ////////////////////////////////////////////////////////////////////////////

  // next grant from the driven requests, then timer updates
  task automatic modelStep();
    int                  nextPort;
    int                  cand;
    logic [numPorts-1:0] run;
    run      = '0;
    nextPort = -1;
    if (modelPort < 0)
    begin
      for (int k = numPorts - 1; k >= 0; k--)
        if (drvReq[k])
          nextPort = k;
    end
    else if (drvReq[modelPort] && modelCount[modelPort] != modelLimit[modelPort])
    begin
      nextPort       = modelPort;
      run[modelPort] = 1'b1;
    end
    else
    begin
      for (int k = 1; k < numPorts && nextPort < 0; k++)
      begin
        cand = (modelPort + k) % numPorts;
        if (drvReq[cand])
          nextPort = cand;
      end
    end
    for (int p = 0; p < numPorts; p++)
    begin
      if (drvFlit[p].head.flitId == flitIdHead)
        modelLimit[p] = drvFlit[p].head.length;
      modelCount[p] = run[p] ? modelCount[p] + 1'b1 : '0;
    end
    modelPort = nextPort;
    expFlit   = (nextPort < 0) ? flitWord'('0) : drvFlit[nextPort];
  endtask

  task automatic driveCycle(input int r);
    logic [1:0] kind;
    drvReq = rowReq[r];
    for (int p = 0; p < numPorts; p++)
    begin
      kind       = rowKinds[r][2*p +: 2];
      lcgState   = lcgStep(lcgState);
      drvFlit[p] = makeFlit(kind, p, rowLen[r], lcgState);
    end
    modelStep();
  endtask

  task automatic checkOutputs(input int r, input int k);
    logic [numPorts-1:0] expGrant;
    string               tag;
    expGrant = '0;
    if (modelPort >= 0)
      expGrant[modelPort] = 1'b1;
    tag = $sformatf("%s cycle %0d", rowName[r], k);
    checkValue({tag, " outGrant"}, 32'(expGrant), 32'(outGrant));
    checkValue({tag, " outValid"}, 32'(modelPort >= 0), 32'(outValid));
    checkValue({tag, " outHead"}, 32'(expFlit.head.flitId == flitIdHead), 32'(outHead));
    checkValue({tag, " outFlit"}, expFlit, outFlit);
    if (k < rowSeq[r].len())
      checkValue({tag, " table grant"}, 32'(grantOfLetter(rowSeq[r][k])), 32'(outGrant));
  endtask

  initial
  begin
    rst         = 1'b1;
    drvReq      = '0;
    lcgState    = 32'd16703;
    errorCount  = 0;
    checkCount  = 0;
    totalCycles = 0;
    tableReady  = 1'b0;
    modelPort   = -1;
    expFlit     = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      drvFlit[p]    = '0;
      modelLimit[p] = '0;
      modelCount[p] = '0;
    end
    buildTable();
    tableReady = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int r = 0; r < rowName.size(); r++)
    begin
      for (int k = 0; k < rowCycles[r]; k++)
      begin
        driveCycle(r);
        @(posedge clk);
        #1;
        checkOutputs(r, k);
      end
    end
    errorCount += routerOutputPort_inst.assertCheck.assertErrors;
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // watchdog, table length plus reset and margin
  initial
  begin
    wait (tableReady);
    #((totalCycles + 25) * 10);
    $display("watchdog expired, the stimulus did not finish in %0d cycles", totalCycles + 25);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== all.f ====
flitPkg.sv
arbPkg.sv
holdTimer.sv
portArbiter.sv
flitStage.sv
outputMux.sv
routerOutputPort.sv
routerOutputPort_assertions.sv
tb_routerOutputPort.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_routerOutputPort -f all.f -o simv

./obj_dir/simv | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
